/* fp16_mult.f */
+incdir+include
rtl/fp16_pkg.sv
rtl/fp16_job_if.sv
rtl/fp16_operand_classifier.sv
rtl/fp16_job_fifo.sv
rtl/fp16_mult_core.sv
rtl/fp16_mult.sv
tb/fp16_mult_checker.sv
tb/fp16_mult_tb.sv

/* include/fp16_defs.svh */
`ifndef FP16_DEFS_SVH
`define FP16_DEFS_SVH

// binary16 word layout
`define FP16_W 16
`define FP16_EXP_W 5
`define FP16_MAN_W 10

// exponent bias of the half-precision format
`define FP16_BIAS 15

// all-ones exponent marks inf and nan
`define FP16_EXP_MAX 5'h1f

// canonical quiet nan returned for every invalid product
`define FP16_QNAN 16'h7E00

// job buffer entries, power of two
`define JOB_FIFO_DEPTH 4

`endif

/* rtl/fp16_job_fifo.sv */
`timescale 1ns/1ps

`include "fp16_defs.svh"

module fp16_job_fifo
  import fp16_pkg::*;
(
  input  logic        clk,
  input  logic        n_rst,
  fp16_job_if.fifo_wr wr,
  fp16_job_if.fifo_rd rd
);

  localparam int DEPTH = `JOB_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  mult_job_t      mem [DEPTH];
  logic [AW-1:0]  wr_ptr;
  logic [AW-1:0]  rd_ptr;
  logic [AW:0]    count;
  logic           do_push;
  logic           do_pop;

  assign do_push = wr.push && !wr.full;
  assign do_pop  = rd.pop && !rd.empty;

  // levels straight from the occupancy count
  assign wr.full  = (count == (AW + 1)'(DEPTH));
  assign rd.empty = (count == '0);

  // head entry
  assign rd.job = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wr.job;
    end
  end

  // pointers wrap naturally since depth is a power of two
  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_push_when_full: assert property (
    @(posedge clk) disable iff (!n_rst) wr.push |-> !wr.full
  );

  a_no_pop_when_empty: assert property (
    @(posedge clk) disable iff (!n_rst) rd.pop |-> !rd.empty
  );

endmodule

/* rtl/fp16_job_if.sv */
`timescale 1ns/1ps

interface fp16_job_if
  import fp16_pkg::*;
();

  logic      push;
  mult_job_t job;
  logic      full;
  logic      empty;
  logic      pop;

  // producer side
  modport src (output push, output job, input full);

  // consumer side
  modport dst (input job, input empty, output pop);

  // buffer write side, serves a producer
  modport fifo_wr (input push, input job, output full);

  // buffer read side, head entry valid while not empty
  modport fifo_rd (output job, output empty, input pop);

endinterface

/* rtl/fp16_mult.sv */
`timescale 1ns/1ps

`include "fp16_defs.svh"

module fp16_mult
  import fp16_pkg::*;
(
  input  logic                clk,
  input  logic                n_rst,
  input  logic                in_valid,
  input  logic [`FP16_W-1:0]  a,
  input  logic [`FP16_W-1:0]  b,
  output logic                busy,
  output logic                out_valid,
  output logic [`FP16_W-1:0]  product
);

  fp16_t op_a;
  fp16_t op_b;
  fp16_t product_w;

  // classifier to buffer, and buffer to core
  fp16_job_if in_link ();
  fp16_job_if out_link ();

  assign op_a.raw = a;
  assign op_b.raw = b;

  fp16_operand_classifier u_classifier (
    .clk      (clk),
    .n_rst    (n_rst),
    .in_valid (in_valid),
    .a        (op_a),
    .b        (op_b),
    .busy     (busy),
    .link     (in_link.src)
  );

  fp16_job_fifo u_fifo (
    .clk   (clk),
    .n_rst (n_rst),
    .wr    (in_link.fifo_wr),
    .rd    (out_link.fifo_rd)
  );

  fp16_mult_core u_core (
    .clk       (clk),
    .n_rst     (n_rst),
    .link      (out_link.dst),
    .out_valid (out_valid),
    .product   (product_w)
  );

  assign product = product_w.raw;

endmodule

/* rtl/fp16_mult_core.sv */
`timescale 1ns/1ps

`include "fp16_defs.svh"

module fp16_mult_core
  import fp16_pkg::*;
(
  input  logic     clk,
  input  logic     n_rst,
  fp16_job_if.dst  link,
  output logic     out_valid,
  output fp16_t    product
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_MULT,
    S_DENORM,
    S_NORM,
    S_ROUND,
    S_EMIT
  } state_t;

  state_t            state;
  mult_job_t         job_r;
  logic [21:0]       mant_r;
  logic signed [7:0] exp_r;
  logic              sticky_r;
  fp16_t             result_r;

  logic [10:0]       sig_a;
  logic [10:0]       sig_b;
  logic [4:0]        eff_a;
  logic [4:0]        eff_b;
  logic signed [7:0] exp_sum;
  logic [4:0]        lz;
  logic signed [7:0] exp_n;
  logic              guard;
  logic              rnd;
  logic              stk;
  logic              round_up;
  logic [11:0]       sum;
  logic [10:0]       man_fin;
  logic signed [7:0] exp_fin;
  fp16_t             rounded;
  fp16_t             bypass_word;

  function automatic logic [4:0] lead_zeros(input logic [21:0] v);
    logic [4:0] n;
    n = 5'd0;
    // highest set bit wins
    for (int i = 0; i < 22; i++) begin
      if (v[i]) begin
        n = 5'(21 - i);
      end
    end
    return n;
  endfunction

  // hidden bit, and subnormals use exponent 1
  assign sig_a   = {job_r.a.f.exp != '0, job_r.a.f.man};
  assign sig_b   = {job_r.b.f.exp != '0, job_r.b.f.man};
  assign eff_a   = (job_r.a.f.exp == '0) ? 5'd1 : job_r.a.f.exp;
  assign eff_b   = (job_r.b.f.exp == '0) ? 5'd1 : job_r.b.f.exp;
  // biased exponent for a leading one at bit 21
  assign exp_sum = $signed({3'b000, eff_a}) + $signed({3'b000, eff_b})
                   - 8'(`FP16_BIAS - 1);

  assign lz    = lead_zeros(mant_r);
  assign exp_n = exp_r - $signed({3'b000, lz});

  // round to nearest, ties to even
  always_comb begin
    guard    = mant_r[10];
    rnd      = mant_r[9];
    stk      = (|mant_r[8:0]) | sticky_r;
    round_up = guard & (rnd | stk | mant_r[11]);
    sum      = {1'b0, mant_r[21:11]} + {11'd0, round_up};
    if (sum[11]) begin
      man_fin = sum[11:1];
      exp_fin = exp_r + 8'sd1;
    end else begin
      man_fin = sum[10:0];
      exp_fin = exp_r;
    end
    rounded.f.sign = job_r.a.f.sign ^ job_r.b.f.sign;
    if (exp_fin >= 8'sd31) begin
      rounded.f.exp = `FP16_EXP_MAX;
      rounded.f.man = '0;
    end else begin
      // no hidden bit left means subnormal
      rounded.f.exp = man_fin[10] ? exp_fin[4:0] : 5'd0;
      rounded.f.man = man_fin[9:0];
    end
  end

  // rebuild the special result from sign and class
  always_comb begin
    case (job_r.res_class)
      CLS_NAN: bypass_word.raw = `FP16_QNAN;
      CLS_INF: bypass_word.raw = {job_r.res_sign, `FP16_EXP_MAX, 10'd0};
      default: bypass_word.raw = {job_r.res_sign, 15'd0};
    endcase
  end

  assign link.pop = (state == S_IDLE) && !link.empty;

  always_ff @(posedge clk) begin
    if (link.pop) begin
      job_r <= link.job;
    end
    case (state)
      S_MULT: begin
        mant_r   <= sig_a * sig_b;
        exp_r    <= exp_sum;
        sticky_r <= 1'b0;
      end
      S_NORM: begin
        if (exp_n < -8'sd11) begin
          // too small even for the guard bit, flush to sticky
          mant_r   <= '0;
          sticky_r <= 1'b1;
          exp_r    <= 8'sd1;
        end else begin
          mant_r <= mant_r << lz;
          exp_r  <= exp_n;
        end
      end
      S_DENORM: begin
        mant_r   <= mant_r >> 1;
        sticky_r <= sticky_r | mant_r[0];
        exp_r    <= exp_r + 8'sd1;
      end
      S_ROUND: begin
        result_r <= rounded;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      state     <= S_IDLE;
      out_valid <= 1'b0;
      product   <= '0;
    end else begin
      out_valid <= 1'b0;
      case (state)
        S_IDLE: begin
          if (link.pop) begin
            state <= link.job.bypass ? S_EMIT : S_MULT;
          end
        end
        S_MULT: state <= S_NORM;
        S_NORM: begin
          if (exp_n < -8'sd11 || exp_n >= 8'sd1) begin
            state <= S_ROUND;
          end else begin
            state <= S_DENORM;
          end
        end
        S_DENORM: begin
          // last shift brings the exponent to 1
          if (exp_r == 8'sd0) begin
            state <= S_ROUND;
          end
        end
        S_ROUND: state <= S_EMIT;
        S_EMIT: begin
          out_valid <= 1'b1;
          product   <= job_r.bypass ? bypass_word : result_r;
          state     <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  a_out_valid_pulse: assert property (
    @(posedge clk) disable iff (!n_rst) out_valid |=> !out_valid
  );

  // popped job comes out within the longest denormalize run of 12 shifts
  a_job_latency: assert property (
    @(posedge clk) disable iff (!n_rst) link.pop |-> ##[2:17] out_valid
  );

endmodule

/* rtl/fp16_operand_classifier.sv */
`timescale 1ns/1ps

`include "fp16_defs.svh"

module fp16_operand_classifier
  import fp16_pkg::*;
(
  input  logic          clk,
  input  logic          n_rst,
  input  logic          in_valid,
  input  fp16_t         a,
  input  fp16_t         b,
  output logic          busy,
  fp16_job_if.src       link
);

  op_class_t cls_a;
  op_class_t cls_b;
  mult_job_t job_next;
  mult_job_t job_r;
  logic      push_r;

  function automatic op_class_t classify(input fp16_t x);
    if (x.f.exp == `FP16_EXP_MAX) begin
      return (x.f.man == '0) ? CLS_INF : CLS_NAN;
    end
    if (x.f.exp == '0 && x.f.man == '0) begin
      return CLS_ZERO;
    end
    // subnormals count as finite
    return CLS_FINITE;
  endfunction

  assign cls_a = classify(a);
  assign cls_b = classify(b);

  // special-case priority: nan, inf, zero
  always_comb begin
    job_next.a         = a;
    job_next.b         = b;
    job_next.res_sign  = a.f.sign ^ b.f.sign;
    job_next.bypass    = 1'b1;
    job_next.res_class = CLS_FINITE;
    if (cls_a == CLS_NAN || cls_b == CLS_NAN) begin
      job_next.res_class = CLS_NAN;
    end else if ((cls_a == CLS_INF && cls_b == CLS_ZERO) ||
                 (cls_a == CLS_ZERO && cls_b == CLS_INF)) begin
      // inf times zero is invalid
      job_next.res_class = CLS_NAN;
    end else if (cls_a == CLS_INF || cls_b == CLS_INF) begin
      job_next.res_class = CLS_INF;
    end else if (cls_a == CLS_ZERO || cls_b == CLS_ZERO) begin
      job_next.res_class = CLS_ZERO;
    end else begin
      job_next.bypass = 1'b0;
    end
  end

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      push_r <= 1'b0;
    end else begin
      push_r <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      job_r <= job_next;
    end
  end

  assign link.push = push_r;
  assign link.job  = job_r;
  assign busy      = link.full;

  // caller must hold off while the buffer is full
  a_no_strobe_when_busy: assert property (
    @(posedge clk) disable iff (!n_rst) in_valid |-> !link.full
  );

endmodule

/* rtl/fp16_pkg.sv */
package fp16_pkg;

  `include "fp16_defs.svh"

  // field view of a half-precision word
  typedef struct packed {
    logic                   sign;
    logic [`FP16_EXP_W-1:0] exp;
    logic [`FP16_MAN_W-1:0] man;
  } fp16_fields_t;

  // same word, seen raw or split into fields
  typedef union packed {
    logic [`FP16_W-1:0] raw;
    fp16_fields_t       f;
  } fp16_t;

  // class of a single operand or of a bypass result
  typedef enum logic [1:0] {
    CLS_ZERO   = 2'd0,
    CLS_FINITE = 2'd1,
    CLS_INF    = 2'd2,
    CLS_NAN    = 2'd3
  } op_class_t;

  // one multiply job as it sits in the buffer
  // special results are kept as sign plus class, not a full word
  typedef struct packed {
    fp16_t     a;
    fp16_t     b;
    logic      bypass;
    logic      res_sign;
    op_class_t res_class;
  } mult_job_t;

endpackage

/* tb/fp16_mult_checker.sv */
`timescale 1ns/1ps

`include "fp16_defs.svh"

module fp16_mult_checker (
  input  logic        clk,
  input  logic        n_rst,
  input  logic        in_valid,
  input  logic        busy,
  input  logic [15:0] expected,
  input  logic        out_valid,
  input  logic [15:0] product,
  output int          error_count,
  output int          result_count,
  output int          pending
);

  // expected products in strobe order
  logic [15:0] exp_q [$];
  logic [15:0] want;

  always @(posedge clk) begin
    if (!n_rst) begin
      error_count  = 0;
      result_count = 0;
      pending      = 0;
      exp_q.delete();
    end else begin
      // a full buffer holds a whole buffer of owed results
      if (busy && exp_q.size() < `JOB_FIFO_DEPTH) begin
        $display("at %0t ns: busy is high with only %0d operations outstanding",
                 $time, exp_q.size());
        error_count++;
      end
      if (out_valid) begin
        result_count++;
        if (exp_q.size() == 0) begin
          $display("at %0t ns: product %h came out with no operation outstanding",
                   $time, product);
          error_count++;
        end else begin
          want = exp_q.pop_front();
          if (product !== want) begin
            $display("** Error at %0t ns: product expected %h, got %h", $time, want, product);
            error_count++;
          end
        end
      end
      // a strobe seen at this edge owes one result
      if (in_valid) begin
        exp_q.push_back(expected);
      end
      pending = exp_q.size();
    end
  end

endmodule

/* tb/fp16_mult_tb.sv */
`timescale 1ns/1ps

`include "fp16_defs.svh"

module fp16_mult_tb;

  localparam int N_TABLE  = 34;
  localparam int N_BURST  = 20;
  localparam int N_RANDOM = 200;
  localparam int N_OPS    = N_TABLE + N_BURST + N_RANDOM;
  // about 20 cycles covers the slowest job including a full denormalize run
  localparam int TIMEOUT_CYCLES = (N_OPS + 4) * 20;

  logic        clk;
  logic        n_rst;
  logic        in_valid;
  logic [15:0] a;
  logic [15:0] b;
  logic [15:0] expected;
  logic        busy;
  logic        out_valid;
  logic [15:0] product;
  int          error_count;
  int          result_count;
  int          pending;
  int          tb_errors;
  int          cycle_count;
  integer      seed;
  logic        busy_seen;

  // each row is {a, b, expected product}
  logic [47:0] dir_table [0:N_TABLE-1] = '{
    48'h3e00_4000_4200, 48'hbe00_4000_c200, 48'hc000_c200_4600, 48'h3c00_3c00_3c00,
    // ties and near ties
    48'h3c01_3e00_3e02, 48'h3c03_3e00_3e04, 48'h3c01_3e01_3e03, 48'h3c01_3dff_3e00,
    // nan, inf times zero, inf, signed zero
    48'h7e00_3c00_7e00, 48'h7c01_3c00_7e00, 48'hfe00_0000_7e00, 48'h7c00_0000_7e00,
    48'h8000_fc00_7e00, 48'h7c00_7e01_7e00, 48'h7c00_c000_fc00, 48'hfc00_bc00_7c00,
    48'h0000_c000_8000, 48'h8000_8000_0000, 48'h8000_0001_8000,
    // subnormal operands and underflow
    48'h0001_3c00_0001, 48'h0200_4000_0400, 48'h0001_7800_1800, 48'h0400_3800_0200,
    48'h0001_3800_0000, 48'h0001_3a00_0001, 48'h0001_0001_0000, 48'h8001_0001_8000,
    48'h0003_3800_0002, 48'h03ff_3c01_0400,
    // overflow
    48'h7bff_4000_7c00, 48'h7800_7800_7c00, 48'hc000_7bff_fc00, 48'h7bff_3c00_7bff,
    48'h7bff_3c01_7c00
  };

  fp16_mult dut (
    .clk       (clk),
    .n_rst     (n_rst),
    .in_valid  (in_valid),
    .a         (a),
    .b         (b),
    .busy      (busy),
    .out_valid (out_valid),
    .product   (product)
  );

  fp16_mult_checker chk (
    .clk          (clk),
    .n_rst        (n_rst),
    .in_valid     (in_valid),
    .busy         (busy),
    .expected     (expected),
    .out_valid    (out_valid),
    .product      (product),
    .error_count  (error_count),
    .result_count (result_count),
    .pending      (pending)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // binary16 product with integer arithmetic, value = sig_p * 2^e
  function automatic logic [15:0] model_product(input logic [15:0] x, input logic [15:0] y);
    logic       sign;
    logic       x_nan;
    logic       y_nan;
    logic       x_inf;
    logic       y_inf;
    logic       x_zero;
    logic       y_zero;
    logic [4:0] exp_field;
    longint     sig_p;
    longint     m;
    longint     rem;
    longint     half;
    int         e;
    int         p;
    int         eb;
    int         shift;
    sign   = x[15] ^ y[15];
    x_nan  = (x[14:10] == 5'h1f) && (x[9:0] != 0);
    y_nan  = (y[14:10] == 5'h1f) && (y[9:0] != 0);
    x_inf  = (x[14:10] == 5'h1f) && (x[9:0] == 0);
    y_inf  = (y[14:10] == 5'h1f) && (y[9:0] == 0);
    x_zero = (x[14:0] == 0);
    y_zero = (y[14:0] == 0);
    if (x_nan || y_nan || (x_inf && y_zero) || (x_zero && y_inf)) begin
      return 16'h7e00;
    end
    if (x_inf || y_inf) begin
      return {sign, 5'h1f, 10'h0};
    end
    if (x_zero || y_zero) begin
      return {sign, 15'h0};
    end
    sig_p = (((x[14:10] != 0) ? 1024 : 0) + x[9:0]) * (((y[14:10] != 0) ? 1024 : 0) + y[9:0]);
    e = ((x[14:10] == 0) ? 1 : x[14:10]) + ((y[14:10] == 0) ? 1 : y[14:10]) - 50;
    p = 0;
    for (int i = 0; i < 24; i++) begin
      if (sig_p[i]) begin
        p = i;
      end
    end
    // biased exponent of the leading one, clamped to the subnormal range
    eb = p + e + 15;
    if (eb < 1) begin
      eb = 1;
    end
    shift = (eb - 25) - e;
    if (shift <= 0) begin
      m = sig_p << (-shift);
    end else begin
      m    = sig_p >> shift;
      rem  = sig_p - (m << shift);
      half = 64'sd1 << (shift - 1);
      if (rem > half || (rem == half && m[0])) begin
        m++;
      end
    end
    if (m >= 2048) begin
      m = m >> 1;
      eb++;
    end
    if (eb >= 31) begin
      return {sign, 5'h1f, 10'h0};
    end
    exp_field = (m >= 1024) ? eb[4:0] : 5'd0;
    return {sign, exp_field, m[9:0]};
  endfunction

  // waits for room, then presents one operand pair for a single edge
  task automatic issue_op(input logic [15:0] op_a, input logic [15:0] op_b,
                          input logic [15:0] exp_v);
    // classifier register holds one job that busy does not yet show
    while (busy || pending > `JOB_FIFO_DEPTH) begin
      if (busy) begin
        busy_seen = 1'b1;
      end
      in_valid = 1'b0;
      @(posedge clk);
      #2;
    end
    in_valid = 1'b1;
    a        = op_a;
    b        = op_b;
    expected = exp_v;
    @(posedge clk);
    #2;
  endtask

  task automatic drain_results();
    in_valid = 1'b0;
    while (pending != 0) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic report_test(input string name, input int ops, input int errs_before);
    $display("test %s: %0d operations, %0d errors", name, ops, error_count - errs_before);
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout after %0d cycles, %0d results never came out", cycle_count, pending);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    int          errs;
    logic [15:0] oa;
    logic [15:0] ob;
    n_rst     = 1'b0;
    in_valid  = 1'b0;
    a         = '0;
    b         = '0;
    expected  = '0;
    tb_errors = 0;
    busy_seen = 1'b0;
    seed      = 32'hdd8fd961;
    repeat (8) @(posedge clk);
    #2;
    n_rst = 1'b1;
    @(posedge clk);
    #2;

    errs = error_count;
    for (int i = 0; i < N_TABLE; i++) begin
      if (model_product(dir_table[i][47:32], dir_table[i][31:16]) !== dir_table[i][15:0]) begin
        $display("table row %0d disagrees with the reference model", i);
        tb_errors++;
      end
      issue_op(dir_table[i][47:32], dir_table[i][31:16], dir_table[i][15:0]);
    end
    drain_results();
    report_test("directed", N_TABLE, errs);

    // slow subnormal results so the FIFO fills up
    errs      = error_count;
    busy_seen = 1'b0;
    for (int i = 0; i < N_BURST; i++) begin
      oa = 16'h0800 + 16'(i * 19);
      ob = 16'h3000 + 16'(i);
      issue_op(oa, ob, model_product(oa, ob));
    end
    drain_results();
    if (!busy_seen) begin
      $display("burst never raised busy, the job FIFO did not fill");
      tb_errors++;
    end
    report_test("burst", N_BURST, errs);

    errs = error_count;
    for (int i = 0; i < N_RANDOM; i++) begin
      oa = 16'($random(seed));
      ob = 16'($random(seed));
      issue_op(oa, ob, model_product(oa, ob));
    end
    drain_results();
    report_test("random", N_RANDOM, errs);

    $display("%0d operations, %0d results, %0d errors", N_OPS, result_count,
             error_count + tb_errors);
    if (error_count + tb_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
